// File: Makefile
# Verilator build and simulation of the core shell testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= pocket_core_shell.f
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_core_top.sv
// Testbench for the core shell top level
// directed tests of the bridge settings, download flags, core reset,
// save table word and the video output path
`default_nettype none

module tb_core_top;

  localparam int CLK_PERIOD      = 4;
  localparam int HOLD            = int'(shell_pkg::RESET_HOLD_CYCLES);
  localparam int WATCHDOG_CYCLES = HOLD + 2000;

  logic                       clk_74a;
  logic                       pll_core_locked;
  shell_pkg::bridge_addr_t    bridge_addr;
  logic                       bridge_wr;
  shell_pkg::bridge_data_t    bridge_wr_data;
  shell_pkg::save_blocks_t    save_size;
  logic                       has_rtc;
  video_pkg::core_video_t     core_video;
  logic                       is_vertical;
  shell_pkg::core_settings_t  settings;
  shell_pkg::download_flags_t downloads;
  logic                       core_reset;
  logic                       datatable_wren;
  shell_pkg::datatable_addr_t datatable_addr;
  shell_pkg::bridge_data_t    datatable_data;
  logic                       video_de;
  video_pkg::rgb_t            video_rgb;
  logic                       video_hs;
  logic                       video_vs;

  int          checks;
  int          errors;
  logic [31:0] lfsr_state;

  // video reference model state
  video_pkg::core_video_t last_driven;
  video_pkg::core_video_t sample_before;
  logic [1:0]             orient_mode;
  int                     edge_index;
  int                     hs_trigger_edge;

  core_top i_dut (.*);

  initial begin
    clk_74a = 1'b0;
    forever #(CLK_PERIOD / 2) clk_74a = ~clk_74a;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // helpers

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_random_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge_addr    <= addr;
    bridge_wr_data <= data;
    bridge_wr      <= 1'b1;
    @(posedge clk_74a);
    bridge_wr <= 1'b0;
  endtask

  task automatic expect_idle_outputs(input string name);
    compare_word(name, '0, 32'(settings));
    compare_word(name, '0, 32'(downloads));
    compare_word(name, '0, 32'({core_reset, datatable_wren, video_hs, video_vs, video_de}));
    compare_word(name, '0, 32'(video_rgb));
  endtask

  ////////////////////////////////////////
  // tests

  task automatic reset_values();
    @(posedge clk_74a);
    @(negedge clk_74a);
    expect_idle_outputs("reset_values active");
    @(posedge clk_74a);
    pll_core_locked <= 1'b1;
    @(negedge clk_74a);
    expect_idle_outputs("reset_values released");
  endtask

  task automatic settings_writes();
    shell_pkg::bridge_addr_t   addrs [8];
    shell_pkg::core_settings_t expected;
    logic [1:0]                low;
    addrs = '{shell_pkg::ADDR_SYSTEM, shell_pkg::ADDR_CPU_TURBO, shell_pkg::ADDR_TRIPLE_BUFFER,
              shell_pkg::ADDR_FLICKERBLEND, shell_pkg::ADDR_ORIENTATION, shell_pkg::ADDR_FLIP_H,
              shell_pkg::ADDR_FASTFORWARD_SOUND, shell_pkg::ADDR_SYSTEM};
    expected = '0;
    for (int r = 0; r < 3; r++) begin
      low = 2'(3 - r);
      for (int i = 0; i < 8; i++) begin
        // upper data bits set, only the low field bits count
        bridge_write(addrs[i], 32'hFFFF_FFFC | 32'(low));
        case (addrs[i])
          shell_pkg::ADDR_SYSTEM:            expected.system = low;
          shell_pkg::ADDR_CPU_TURBO:         expected.cpu_turbo = low[0];
          shell_pkg::ADDR_TRIPLE_BUFFER:     expected.triple_buffer = low[0];
          shell_pkg::ADDR_FLICKERBLEND:      expected.flickerblend = low;
          shell_pkg::ADDR_ORIENTATION: begin
            expected.orientation = video_pkg::orientation_mode_t'(low);
          end
          shell_pkg::ADDR_FLIP_H:            expected.flip_horizontal = low[0];
          default:                           expected.fastforward_sound = low[0];
        endcase
        @(negedge clk_74a);
        compare_word("settings_writes", 32'(expected), 32'(settings));
      end
    end
    // unmapped addresses
    bridge_write(32'h0000_0104, 32'hFFFF_FFFF);
    bridge_write(32'h8000_0100, 32'hFFFF_FFFF);
    @(negedge clk_74a);
    compare_word("settings_writes unmapped", 32'(expected), 32'(settings));
    compare_word("settings_writes unmapped flags", '0, 32'(downloads));
  endtask

  task automatic flag_step(input logic [31:0] addr, input logic b, input logic [4:0] expected);
    bridge_write(addr, {31'h7FFF_FFFF, b});
    @(negedge clk_74a);
    compare_word("download_flags", 32'(expected), 32'(downloads));
  endtask

  task automatic download_flags();
    logic       c;
    logic       d;
    logic [1:0] cart_expected [4];
    // index is {is_color_cart, cart_download}
    cart_expected = '{2'b00, 2'b01, 2'b00, 2'b10};
    for (int k = 0; k < 4; k++) begin
      c = k[1];
      d = k[0];
      bridge_write(shell_pkg::ADDR_IS_COLOR_CART, {31'h7FFF_FFFF, c});
      bridge_write(shell_pkg::ADDR_CART_DOWNLOAD, {31'h7FFF_FFFF, d});
      @(negedge clk_74a);
      compare_word("download_flags cart", 32'(cart_expected[k]), 32'(downloads.cart));
    end
    // fields are cart, bios, save
    flag_step(shell_pkg::ADDR_CART_DOWNLOAD, 1'b0, 5'b00_00_0);
    flag_step(shell_pkg::ADDR_BW_BIOS,       1'b1, 5'b00_01_0);
    flag_step(shell_pkg::ADDR_COLOR_BIOS,    1'b1, 5'b00_11_0);
    flag_step(shell_pkg::ADDR_SAVE_DOWNLOAD, 1'b1, 5'b00_11_1);
    flag_step(shell_pkg::ADDR_BW_BIOS,       1'b0, 5'b00_10_1);
    flag_step(shell_pkg::ADDR_COLOR_BIOS,    1'b0, 5'b00_00_1);
    flag_step(shell_pkg::ADDR_SAVE_DOWNLOAD, 1'b0, 5'b00_00_0);
  endtask

  task automatic save_table_word();
    logic [31:0]             r;
    shell_pkg::save_blocks_t size;
    for (int i = 0; i < 20; i++) begin
      take_random_bits(12, r);
      size = r[11:0];
      for (int rtc = 0; rtc < 2; rtc++) begin
        @(posedge clk_74a);
        save_size <= size;
        has_rtc   <= rtc[0];
        @(posedge clk_74a);
        @(negedge clk_74a);
        // 512-byte blocks plus 12 bytes of clock data
        compare_word("save_table_word data", {11'b0, size, 9'b0} + (rtc[0] ? 32'd12 : 32'd0),
                     datatable_data);
        compare_word("save_table_word addr", 32'd7, 32'(datatable_addr));
        compare_word("save_table_word wren", 32'd1, 32'(datatable_wren));
      end
    end
  endtask

  task automatic core_reset_hold();
    int cycles;
    bridge_write(shell_pkg::ADDR_CORE_RESET, 32'd1);
    @(negedge clk_74a);
    compare_word("core_reset_hold start", 32'd1, 32'(core_reset));
    // a second write restarts the hold
    repeat (50) @(negedge clk_74a);
    bridge_write(shell_pkg::ADDR_CORE_RESET, 32'd0);
    cycles = 0;
    @(negedge clk_74a);
    while (core_reset === 1'b1 && cycles <= HOLD) begin
      cycles++;
      @(negedge clk_74a);
    end
    compare_word("core_reset_hold length", 32'(HOLD), 32'(cycles));
    repeat (4) @(negedge clk_74a);
    compare_word("core_reset_hold end", 32'd0, 32'(core_reset));
  endtask

  ////////////////////////////////////////
  // video

  // drives one input word and checks what the edge before produced
  task automatic video_cycle(input video_pkg::core_video_t v);
    video_pkg::core_video_t sample_now;
    logic                   de_now;
    logic                   de_before;
    logic                   slot_vertical;
    video_pkg::rgb_t        exp_rgb;
    logic                   exp_hs;
    logic                   exp_vs;
    @(posedge clk_74a);
    core_video <= v;
    edge_index++;
    sample_now  = last_driven;
    last_driven = v;
    de_now      = ~(sample_now.hblank | sample_now.vblank);
    de_before   = ~(sample_before.hblank | sample_before.vblank);
    slot_vertical = (orient_mode == 2'd0) ? is_vertical : (orient_mode == 2'd2);
    if (de_now) begin
      exp_rgb = sample_now.rgb;
    end else if (de_before) begin
      exp_rgb = video_pkg::rgb_t'(slot_vertical) << video_pkg::SLOT_BIT;
    end else begin
      exp_rgb = '0;
    end
    exp_vs = sample_now.vsync & ~sample_before.vsync;
    if (sample_now.hsync & ~sample_before.hsync) begin
      hs_trigger_edge = edge_index;
    end
    // registered seven edges after the trigger, sampled on the eighth
    exp_hs = (edge_index - hs_trigger_edge == 7);
    sample_before = sample_now;
    @(negedge clk_74a);
    compare_word("video_output de", 32'(de_now), 32'(video_de));
    compare_word("video_output rgb", 32'(exp_rgb), 32'(video_rgb));
    compare_word("video_output hs", 32'(exp_hs), 32'(video_hs));
    compare_word("video_output vs", 32'(exp_vs), 32'(video_vs));
  endtask

  task automatic video_line(input logic vblank_line);
    video_pkg::core_video_t v;
    logic [31:0]            r;
    for (int i = 0; i < 24; i++) begin
      take_random_bits(24, r);
      v.hblank = (i < 3) || (i >= 7);
      v.vblank = vblank_line;
      v.hsync  = (i == 9) || (i == 10);
      v.vsync  = vblank_line && (i >= 1) && (i <= 3);
      v.rgb    = r[23:0];
      video_cycle(v);
    end
  endtask

  task automatic video_output();
    last_driven     = core_video;
    sample_before   = core_video;
    edge_index      = 0;
    hs_trigger_edge = -100;
    for (int k = 0; k < 8; k++) begin
      orient_mode = 2'(k >> 1);
      bridge_write(shell_pkg::ADDR_ORIENTATION, 32'(orient_mode));
      @(posedge clk_74a);
      is_vertical <= k[0];
      video_line(1'b1);
      video_line(1'b0);
      video_line(1'b0);
    end
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    checks            = 0;
    errors            = 0;
    lfsr_state        = 32'h616e;
    orient_mode       = 2'd0;
    pll_core_locked   = 1'b0;
    bridge_addr       = '0;
    bridge_wr         = 1'b0;
    bridge_wr_data    = '0;
    save_size         = '0;
    has_rtc           = 1'b0;
    core_video        = '0;
    core_video.hblank = 1'b1;
    core_video.vblank = 1'b1;
    is_vertical       = 1'b0;

    reset_values();
    settings_writes();
    download_flags();
    save_table_word();
    video_output();
    core_reset_hold();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
// Core shell top level
// connects the host settings block and the video output path
// between the bridge, the emulator core and the scaler
`default_nettype none

module core_top (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,

  ////////////////////////////////////////
  // bridge

  input  shell_pkg::bridge_addr_t      bridge_addr,
  input  wire                          bridge_wr,
  input  shell_pkg::bridge_data_t      bridge_wr_data,

  ////////////////////////////////////////
  // emulator core

  input  shell_pkg::save_blocks_t      save_size,
  input  wire                          has_rtc,
  input  video_pkg::core_video_t       core_video,
  input  wire                          is_vertical,
  output shell_pkg::core_settings_t    settings,
  output shell_pkg::download_flags_t   downloads,
  output wire                          core_reset,

  ////////////////////////////////////////
  // data table

  output wire                          datatable_wren,
  output shell_pkg::datatable_addr_t   datatable_addr,
  output shell_pkg::bridge_data_t      datatable_data,

  ////////////////////////////////////////
  // scaler

  output wire                          video_de,
  output video_pkg::rgb_t              video_rgb,
  output wire                          video_hs,
  output wire                          video_vs
);

  host_settings i_host_settings (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge_addr     (bridge_addr),
    .bridge_wr       (bridge_wr),
    .bridge_wr_data  (bridge_wr_data),
    .save_size       (save_size),
    .has_rtc         (has_rtc),
    .settings        (settings),
    .downloads       (downloads),
    .core_reset      (core_reset),
    .datatable_wren  (datatable_wren),
    .datatable_addr  (datatable_addr),
    .datatable_data  (datatable_data)
  );

  video_sync_shaper i_video_sync_shaper (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .core_video      (core_video),
    .video_hs        (video_hs),
    .video_vs        (video_vs)
  );

  // orientation comes from the host settings
  video_pixel_out i_video_pixel_out (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .core_video      (core_video),
    .orientation     (settings.orientation),
    .is_vertical     (is_vertical),
    .video_de        (video_de),
    .video_rgb       (video_rgb)
  );

endmodule

`default_nettype wire

// File: hdl/host_settings.sv
// Host settings block
// decodes bridge writes into the core settings and download flags,
// runs the counted core reset and reports the save size word
`default_nettype none

module host_settings (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,

  // bridge writes
  input  shell_pkg::bridge_addr_t      bridge_addr,
  input  wire                          bridge_wr,
  input  shell_pkg::bridge_data_t      bridge_wr_data,

  // from the emulator core
  input  shell_pkg::save_blocks_t      save_size,
  input  wire                          has_rtc,

  output shell_pkg::core_settings_t    settings,
  output shell_pkg::download_flags_t   downloads,
  output logic                         core_reset,

  // data table port
  output logic                         datatable_wren,
  output shell_pkg::datatable_addr_t   datatable_addr,
  output shell_pkg::bridge_data_t      datatable_data
);

  logic                    cart_download;
  logic                    is_color_cart;
  logic [1:0]              bios_download;
  logic                    save_download;
  shell_pkg::bridge_data_t reset_count;
  shell_pkg::bridge_data_t save_bytes;

  ////////////////////////////////////////
  // bridge write decode

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings      <= '0;
      cart_download <= 1'b0;
      is_color_cart <= 1'b0;
      bios_download <= 2'b00;
      save_download <= 1'b0;
    end else if (bridge_wr) begin
      case (bridge_addr)
        shell_pkg::ADDR_CART_DOWNLOAD: cart_download <= bridge_wr_data[0];
        shell_pkg::ADDR_IS_COLOR_CART: is_color_cart <= bridge_wr_data[0];
        shell_pkg::ADDR_BW_BIOS:       bios_download[0] <= bridge_wr_data[0];
        shell_pkg::ADDR_COLOR_BIOS:    bios_download[1] <= bridge_wr_data[0];
        shell_pkg::ADDR_SAVE_DOWNLOAD: save_download <= bridge_wr_data[0];

        shell_pkg::ADDR_SYSTEM:    settings.system <= bridge_wr_data[1:0];
        shell_pkg::ADDR_CPU_TURBO: settings.cpu_turbo <= bridge_wr_data[0];

        shell_pkg::ADDR_TRIPLE_BUFFER: settings.triple_buffer <= bridge_wr_data[0];
        shell_pkg::ADDR_FLICKERBLEND:  settings.flickerblend <= bridge_wr_data[1:0];
        shell_pkg::ADDR_ORIENTATION: begin
          settings.orientation <= video_pkg::orientation_mode_t'(bridge_wr_data[1:0]);
        end
        shell_pkg::ADDR_FLIP_H: settings.flip_horizontal <= bridge_wr_data[0];

        shell_pkg::ADDR_FASTFORWARD_SOUND: begin
          settings.fastforward_sound <= bridge_wr_data[0];
        end

        default: begin
        end
      endcase
    end
  end

  // the cart type steers the single download bit to mono or colour
  assign downloads.cart = is_color_cart ? {cart_download, 1'b0} : {1'b0, cart_download};
  assign downloads.bios = bios_download;
  assign downloads.save = save_download;

  ////////////////////////////////////////
  // core reset

  // a new write restarts the hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count <= '0;
    end else if (bridge_wr && bridge_addr == shell_pkg::ADDR_CORE_RESET) begin
      reset_count <= shell_pkg::RESET_HOLD_CYCLES;
    end else if (reset_count != '0) begin
      reset_count <= reset_count - 1'b1;
    end
  end

  assign core_reset = (reset_count != '0);

  ////////////////////////////////////////
  // save table word

  // blocks of 512 bytes, rtc words appended
  assign save_bytes = shell_pkg::bridge_data_t'(save_size) * shell_pkg::SAVE_BLOCK_BYTES
                    + (has_rtc ? shell_pkg::RTC_EXTRA_BYTES : '0);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      datatable_wren <= 1'b0;
      datatable_addr <= '0;
    end else begin
      // rewritten every cycle
      datatable_wren <= 1'b1;
      datatable_addr <= shell_pkg::SAVE_TABLE_ADDR;
    end
  end

  always_ff @(posedge clk_74a) begin
    datatable_data <= save_bytes;
  end

endmodule

`default_nettype wire

// File: hdl/shell_pkg.sv
// Host shell definitions
// bridge address map, settings and download flag bundles,
// core reset length and save table constants
`default_nettype none

package shell_pkg;

  ////////////////////////////////////////
  // bridge words

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;

  ////////////////////////////////////////
  // bridge address map

  // download flags
  localparam bridge_addr_t ADDR_CART_DOWNLOAD     = 32'h0000_0000;
  localparam bridge_addr_t ADDR_IS_COLOR_CART     = 32'h0000_0004;
  localparam bridge_addr_t ADDR_BW_BIOS           = 32'h0000_0008;
  localparam bridge_addr_t ADDR_COLOR_BIOS        = 32'h0000_000C;
  localparam bridge_addr_t ADDR_SAVE_DOWNLOAD     = 32'h0000_0010;

  localparam bridge_addr_t ADDR_CORE_RESET        = 32'h0000_0050;

  // system settings
  localparam bridge_addr_t ADDR_SYSTEM            = 32'h0000_0100;
  localparam bridge_addr_t ADDR_CPU_TURBO         = 32'h0000_0110;

  // video settings
  localparam bridge_addr_t ADDR_TRIPLE_BUFFER     = 32'h0000_0200;
  localparam bridge_addr_t ADDR_FLICKERBLEND      = 32'h0000_0204;
  localparam bridge_addr_t ADDR_ORIENTATION       = 32'h0000_0208;
  localparam bridge_addr_t ADDR_FLIP_H            = 32'h0000_020C;

  // audio settings
  localparam bridge_addr_t ADDR_FASTFORWARD_SOUND = 32'h0000_0300;

  ////////////////////////////////////////
  // core reset

  // about 14 ms at 74.25 MHz
  localparam bridge_data_t RESET_HOLD_CYCLES = 32'h0010_0000;

  ////////////////////////////////////////
  // save table

  typedef logic [11:0] save_blocks_t;
  typedef logic [9:0]  datatable_addr_t;

  localparam bridge_data_t SAVE_BLOCK_BYTES = 32'd512;
  // six rtc words after the save data
  localparam bridge_data_t RTC_EXTRA_BYTES  = 32'd12;
  // size word of data slot index 3
  localparam datatable_addr_t SAVE_TABLE_ADDR = 10'd7;

  ////////////////////////////////////////
  // settings and flags

  typedef struct packed {
    logic [1:0]                    system;
    logic                          cpu_turbo;
    logic                          triple_buffer;
    logic [1:0]                    flickerblend;
    video_pkg::orientation_mode_t  orientation;
    logic                          flip_horizontal;
    logic                          fastforward_sound;
  } core_settings_t;

  // colour in the upper bit, mono in the lower
  typedef struct packed {
    logic [1:0] cart;
    logic [1:0] bios;
    logic       save;
  } download_flags_t;

endpackage

`default_nettype wire

// File: hdl/video_pixel_out.sv
// Pixel output stage
// registers data enable and colour for the scaler and puts the
// orientation slot word on the first blank cycle after each line
`default_nettype none

module video_pixel_out (
  input  wire                          clk_74a,
  input  wire                          pll_core_locked,
  input  video_pkg::core_video_t       core_video,
  input  video_pkg::orientation_mode_t orientation,
  input  wire                          is_vertical,
  output logic                         video_de,
  output video_pkg::rgb_t              video_rgb
);

  logic            de;
  logic            de_prev;
  logic            slot_vertical;
  video_pkg::rgb_t slot_word;

  assign de = ~(core_video.hblank | core_video.vblank);

  ////////////////////////////////////////
  // slot word

  // auto follows the core, reserved acts as horizontal
  always_comb begin
    case (orientation)
      video_pkg::ORIENT_AUTO:     slot_vertical = is_vertical;
      video_pkg::ORIENT_VERTICAL: slot_vertical = 1'b1;
      default:                    slot_vertical = 1'b0;
    endcase
  end

  always_comb begin
    slot_word = '0;
    slot_word[video_pkg::SLOT_BIT] = slot_vertical;
  end

  ////////////////////////////////////////
  // output registers

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev   <= 1'b0;
      video_de  <= 1'b0;
      video_rgb <= '0;
    end else begin
      de_prev  <= de;
      video_de <= de;

      if (de) begin
        video_rgb <= core_video.rgb;
      end else if (de_prev) begin
        // end of active run
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/video_pkg.sv
// Video types for the shell output path
// core video bundle, orientation modes and the scaler
// sync and slot-word constants
`default_nettype none

package video_pkg;

  ////////////////////////////////////////
  // colour and orientation

  typedef logic [23:0] rgb_t;

  // reserved is treated the same as horizontal
  typedef enum logic [1:0] {
    ORIENT_AUTO       = 2'd0,
    ORIENT_HORIZONTAL = 2'd1,
    ORIENT_VERTICAL   = 2'd2,
    ORIENT_RESERVED   = 3
  } orientation_mode_t;

  ////////////////////////////////////////
  // core video bundle

  typedef struct packed {
    logic hblank;
    logic vblank;
    logic hsync;
    logic vsync;
    rgb_t rgb;
  } core_video_t;

  ////////////////////////////////////////
  // scaler sync and slot word

  // hsync delay so it never lands on the vsync pulse
  localparam int unsigned HS_DELAY   = 7;
  localparam int unsigned HS_COUNT_W = $clog2(HS_DELAY + 1);
  typedef logic [HS_COUNT_W-1:0] hs_count_t;

  // bit 13 of the slot word picks the scaler slot
  localparam int unsigned SLOT_BIT = 13;

endpackage

`default_nettype wire

// File: hdl/video_sync_shaper.sv
// Scaler sync shaper
// turns the core's sync levels into single-cycle pulses,
// with hsync held back so it never meets vsync
`default_nettype none

module video_sync_shaper (
  input  wire                    clk_74a,
  input  wire                    pll_core_locked,
  input  video_pkg::core_video_t core_video,
  output logic                   video_hs,
  output logic                   video_vs
);

  logic                  hs_prev;
  logic                  vs_prev;
  logic                  hs_rise;
  logic                  vs_rise;
  video_pkg::hs_count_t  hs_delay;

  ////////////////////////////////////////
  // edge detect

  assign hs_rise = core_video.hsync & ~hs_prev;
  assign vs_rise = core_video.vsync & ~vs_prev;

  ////////////////////////////////////////
  // pulse generation

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      hs_delay <= '0;
      video_hs <= 1'b0;
      video_vs <= 1'b0;
    end else begin
      hs_prev <= core_video.hsync;
      vs_prev <= core_video.vsync;

      // vsync goes straight out
      video_vs <= vs_rise;

      // last count step fires the hsync pulse
      video_hs <= (hs_delay == video_pkg::hs_count_t'(1));

      if (hs_rise) begin
        hs_delay <= video_pkg::hs_count_t'(video_pkg::HS_DELAY);
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: pocket_core_shell.f
hdl/video_pkg.sv
hdl/shell_pkg.sv
hdl/host_settings.sv
hdl/video_sync_shaper.sv
hdl/video_pixel_out.sv
hdl/core_top.sv
bench/tb_core_top.sv
